//--- source/vgaTimingPkg.sv
package vgaTimingPkg;

  // counter value covering the whole 800x525 frame
  typedef logic [9:0] screenCoord_t;

  // canvas is 256x256, so one byte per axis
  typedef logic [7:0] canvasCoord_t;

  // horizontal timing in pixel clocks
  // active, front porch, sync, back porch
  localparam screenCoord_t hActive     = 10'd640;
  localparam screenCoord_t hFrontPorch = 10'd16;
  localparam screenCoord_t hSyncWidth  = 10'd96;
  localparam screenCoord_t hBackPorch  = 10'd48;
  localparam screenCoord_t hTotal      = 10'd800;

  // vertical timing in lines
  localparam screenCoord_t vActive     = 10'd480;
  localparam screenCoord_t vFrontPorch = 10'd10;
  localparam screenCoord_t vSyncWidth  = 10'd2;
  localparam screenCoord_t vBackPorch  = 10'd33;
  localparam screenCoord_t vTotal      = 10'd525;

  // interval bounds derived from the mode
  // sync spans [start, end), back porch runs to total
  localparam screenCoord_t hSyncStart = hActive + hFrontPorch;
  localparam screenCoord_t hSyncEnd   = hSyncStart + hSyncWidth;
  localparam screenCoord_t vSyncStart = vActive + vFrontPorch;
  localparam screenCoord_t vSyncEnd   = vSyncStart + vSyncWidth;

  // last counter values before wrap
  localparam screenCoord_t hLast = hTotal - 10'd1;
  localparam screenCoord_t vLast = vTotal - 10'd1;

endpackage

//--- source/paintPkg.sv
package paintPkg;

  // canvas color code, indexes the palette
  typedef logic [2:0] colorCode_t;

  // one color channel toward the DAC
  typedef logic [3:0] nibble_t;

  // 12-bit pixel, red in the top nibble
  typedef struct packed {
    nibble_t r;
    nibble_t g;
    nibble_t b;
  } rgb_t;

  // whole palette as seen by the output stage
  typedef rgb_t [7:0] paletteTable_t;

  // one byte of the command stream
  typedef logic [7:0] cmdByte_t;

  // single pixel write into the canvas
  typedef struct packed {
    vgaTimingPkg::canvasCoord_t x;
    vgaTimingPkg::canvasCoord_t y;
    colorCode_t                 code;
  } pixelWrite_t;

  // replaces one palette entry
  typedef struct packed {
    colorCode_t index;
    rgb_t       color;
  } paletteWrite_t;

  // opcode field, bits 7:6 of a header byte
  // 2'b10 and 2'b11 reserved
  localparam logic [1:0] opPaint   = 2'b00;
  localparam logic [1:0] opPalette = 2'b01;

  // power-up palette
  // code bit 2 -> red, bit 1 -> green, bit 0 -> blue, full scale
  function automatic rgb_t defaultColor(input colorCode_t c);
    rgb_t col;
    col.r = {4{c[2]}};
    col.g = {4{c[1]}};
    col.b = {4{c[0]}};
    return col;
  endfunction

endpackage

//--- source/vgaController.sv
`timescale 1ns/1ps

module vgaController (
  input  logic                       clk,
  input  logic                       rst,
  output vgaTimingPkg::screenCoord_t scanX,
  output vgaTimingPkg::screenCoord_t scanY,
  output logic                       hsyncRaw,
  output logic                       vsyncRaw,
  output logic                       activeRaw
);

  import vgaTimingPkg::*;

  // counter values for the next clock
  screenCoord_t xNext;
  screenCoord_t yNext;
  logic         lineEnd;

  // x wraps at 799, y steps once per wrap
  assign lineEnd = (scanX == hLast);

  always_comb begin
    xNext = lineEnd ? '0 : scanX + 10'd1;
    yNext = scanY;
    if (lineEnd) begin
      yNext = (scanY == vLast) ? '0 : scanY + 10'd1;
    end
  end

  // counters and decoded raw signals share one register stage
  // so the raw signals always describe the current counter pair
  always_ff @(posedge clk) begin
    if (rst) begin
      scanX     <= '0;
      scanY     <= '0;
      // values match position (0,0), top left of active area
      hsyncRaw  <= 1'b1;
      vsyncRaw  <= 1'b1;
      activeRaw <= 1'b1;
    end else begin
      scanX     <= xNext;
      scanY     <= yNext;
      // sync pulses are active low
      hsyncRaw  <= !((xNext >= hSyncStart) && (xNext < hSyncEnd));
      // vertical sync covers whole lines
      vsyncRaw  <= !((yNext >= vSyncStart) && (yNext < vSyncEnd));
      // visible region 640x480
      activeRaw <= (xNext < hActive) && (yNext < vActive);
    end
  end

endmodule

//--- source/paintCommandDecoder.sv
`timescale 1ns/1ps

module paintCommandDecoder (
  input  logic                    clk,
  input  logic                    rst,
  input  paintPkg::cmdByte_t      cmdByte,
  input  logic                    cmdValid,
  output logic                    cmdReady,
  output paintPkg::pixelWrite_t   pixelWr,
  output logic                    pixelWrEn,
  output paintPkg::paletteWrite_t paletteWr,
  output logic                    paletteWrEn
);

  import paintPkg::*;

  // header, two operand bytes, then one issue cycle
  typedef enum logic [1:0] {
    stHeader,
    stFirst,
    stSecond,
    stIssue
  } decState_t;

  decState_t  state;
  logic       take;
  logic       knownOp;
  // latched command fields
  logic [1:0] opcode;
  colorCode_t hdrArg;
  cmdByte_t   firstByte;
  cmdByte_t   secondByte;

  // only the issue cycle stalls the sender
  assign cmdReady = (state != stIssue);
  assign take     = cmdValid && cmdReady;
  assign knownOp  = (cmdByte[7:6] == opPaint) || (cmdByte[7:6] == opPalette);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stHeader;
    end else begin
      case (state)
        // reserved opcode dropped as a one-byte command
        stHeader: if (take && knownOp) state <= stFirst;
        stFirst:  if (take) state <= stSecond;
        stSecond: if (take) state <= stIssue;
        stIssue:  state <= stHeader;
        default:  state <= stHeader;
      endcase
    end
  end

  // operand capture, one byte per accepted transfer
  always_ff @(posedge clk) begin
    if (take) begin
      case (state)
        stHeader: begin
          opcode <= cmdByte[7:6];
          hdrArg <= cmdByte[2:0];
        end
        stFirst:  firstByte  <= cmdByte;
        stSecond: secondByte <= cmdByte;
        default:  ;
      endcase
    end
  end

  // paint: header code, then x, then y
  assign pixelWr.x    = firstByte;
  assign pixelWr.y    = secondByte;
  assign pixelWr.code = hdrArg;

  // palette: header index, then {r, g}, then {0, b}
  assign paletteWr.index   = hdrArg;
  assign paletteWr.color.r = firstByte[7:4];
  assign paletteWr.color.g = firstByte[3:0];
  assign paletteWr.color.b = secondByte[3:0];

  // exactly one enable per completed command
  assign pixelWrEn   = (state == stIssue) && (opcode == opPaint);
  assign paletteWrEn = (state == stIssue) && (opcode == opPalette);

endmodule

//--- source/pixelStore.sv
`timescale 1ns/1ps

module pixelStore (
  input  logic                       clk,
  input  paintPkg::pixelWrite_t      pixelWr,
  input  logic                       pixelWrEn,
  input  vgaTimingPkg::canvasCoord_t readX,
  input  vgaTimingPkg::canvasCoord_t readY,
  output paintPkg::colorCode_t       readCode
);

  import paintPkg::*;

  // 256x256 codes, row major
  // starts all black from memory init
  colorCode_t canvas [65536] = '{default: '0};

  // {y, x} forms the flat address
  logic [15:0] wrAddr;
  logic [15:0] rdAddr;

  assign wrAddr = {pixelWr.y, pixelWr.x};
  assign rdAddr = {readY, readX};

  // command write port
  always_ff @(posedge clk) begin
    if (pixelWrEn) begin
      canvas[wrAddr] <= pixelWr.code;
    end
  end

  // scan read port, one cycle latency
  // a write to the same address this cycle is seen next frame
  always_ff @(posedge clk) begin
    readCode <= canvas[rdAddr];
  end

endmodule

//--- source/paletteRegs.sv
`timescale 1ns/1ps

module paletteRegs (
  input  logic                    clk,
  input  logic                    rst,
  input  paintPkg::paletteWrite_t paletteWr,
  input  logic                    paletteWrEn,
  output paintPkg::paletteTable_t paletteTable
);

  import paintPkg::*;

  // eight 12-bit entries, indexed by color code
  // reset loads the 3-bit primaries, black through white
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < 8; c++) begin
        paletteTable[c] <= defaultColor(colorCode_t'(c));
      end
    end else if (paletteWrEn) begin
      // single entry rewrite
      paletteTable[paletteWr.index] <= paletteWr.color;
    end
  end

endmodule

//--- source/pixelOutput.sv
`timescale 1ns/1ps

module pixelOutput (
  input  logic                    clk,
  input  logic                    rst,
  input  paintPkg::colorCode_t    code,
  input  paintPkg::paletteTable_t paletteTable,
  input  logic                    hsyncRaw,
  input  logic                    vsyncRaw,
  input  logic                    activeRaw,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blankN,
  output paintPkg::rgb_t          pixel
);

  // raw timing delayed to line up with the store read
  logic hsyncDly;
  logic vsyncDly;
  logic activeDly;

  // stage 1, code still in flight from the canvas
  always_ff @(posedge clk) begin
    if (rst) begin
      hsyncDly  <= 1'b1;
      vsyncDly  <= 1'b1;
      activeDly <= 1'b0;
    end else begin
      hsyncDly  <= hsyncRaw;
      vsyncDly  <= vsyncRaw;
      activeDly <= activeRaw;
    end
  end

  // stage 2, palette lookup and blanking
  // all outputs now describe the same pixel
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      blankN <= 1'b0;
      pixel  <= '0;
    end else begin
      hsync  <= hsyncDly;
      vsync  <= vsyncDly;
      blankN <= activeDly;
      // DAC must see black outside the visible area
      pixel  <= activeDly ? paletteTable[code] : '0;
    end
  end

endmodule

//--- source/vgaPaint.sv
`timescale 1ns/1ps

module vgaPaint (
  input  logic               clk,
  input  logic               rst,
  input  paintPkg::cmdByte_t cmdByte,
  input  logic               cmdValid,
  output logic               cmdReady,
  output logic               hsync,
  output logic               vsync,
  output logic               blankN,
  output paintPkg::rgb_t     pixel
);

  import vgaTimingPkg::*;
  import paintPkg::*;

  // scan position and raw timing
  screenCoord_t scanX;
  screenCoord_t scanY;
  logic         hsyncRaw;
  logic         vsyncRaw;
  logic         activeRaw;

  // command side writes
  pixelWrite_t   pixelWr;
  logic          pixelWrEn;
  paletteWrite_t paletteWr;
  logic          paletteWrEn;

  // read path
  colorCode_t    scanCode;
  paletteTable_t paletteTable;

  vgaController vgaController_i (
    .clk, .rst, .scanX, .scanY, .hsyncRaw, .vsyncRaw, .activeRaw
  );

  paintCommandDecoder paintCommandDecoder_i (
    .clk, .rst, .cmdByte, .cmdValid, .cmdReady,
    .pixelWr, .pixelWrEn, .paletteWr, .paletteWrEn
  );

  // low byte of each counter, so the canvas tiles the screen
  pixelStore pixelStore_i (
    .clk, .pixelWr, .pixelWrEn,
    .readX(scanX[7:0]), .readY(scanY[7:0]), .readCode(scanCode)
  );

  paletteRegs paletteRegs_i (
    .clk, .rst, .paletteWr, .paletteWrEn, .paletteTable
  );

  pixelOutput pixelOutput_i (
    .clk, .rst, .code(scanCode), .paletteTable,
    .hsyncRaw, .vsyncRaw, .activeRaw,
    .hsync, .vsync, .blankN, .pixel
  );

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 100 MHz stand-in for the pixel clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held over the first 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- sim/vgaPaint_asserts.sv
`timescale 1ns/1ps

module vgaPaintAsserts (
  input logic               clk,
  input logic               rst,
  input paintPkg::cmdByte_t cmdByte,
  input logic               cmdValid,
  input logic               cmdReady,
  input logic               hsync,
  input logic               vsync,
  input logic               blankN,
  input paintPkg::rgb_t     pixel
);

  // index of the next byte inside a command
  logic [1:0] byteIdx;
  logic       xfer;

  assign xfer = cmdValid && cmdReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      byteIdx <= 2'd0;
    end else if (xfer) begin
      if (byteIdx == 2'd2) begin
        byteIdx <= 2'd0;
      end else if ((byteIdx == 2'd0) && cmdByte[7]) begin
        // reserved header is a command of its own
        byteIdx <= 2'd0;
      end else begin
        byteIdx <= byteIdx + 2'd1;
      end
    end
  end

  // DAC black outside the visible area
  blankBlack: assert property (@(posedge clk) disable iff (rst) !blankN |-> (pixel == '0))
    else $error("pixel not black while blanked");

  // syncs sit inside the blanking interval
  syncBlanked: assert property (@(posedge clk) disable iff (rst)
    (!hsync || !vsync) |-> !blankN)
    else $error("blankN high during a sync pulse");

  // issue cycle follows the third byte
  issueStall: assert property (@(posedge clk) disable iff (rst)
    (xfer && (byteIdx == 2'd2)) |=> !cmdReady)
    else $error("cmdReady high after a third command byte");

  // stall never lasts past one cycle
  stallOneCycle: assert property (@(posedge clk) disable iff (rst) !cmdReady |=> cmdReady)
    else $error("cmdReady low for more than one cycle");

endmodule

bind vgaPaint vgaPaintAsserts vgaPaintAsserts_i (.*);

//--- sim/vgaPaintTb.sv
`timescale 1ns/1ps

module vgaPaintTb;

  import vgaTimingPkg::*;
  import paintPkg::*;

  // one frame in pixel clocks
  localparam int frameCycles  = int'(hTotal) * int'(vTotal);
  localparam int lockTimeout  = 3 * frameCycles;
  localparam int readyTimeout = 64;

  logic     clk;
  logic     rst;
  cmdByte_t cmdByte;
  logic     cmdValid;
  logic     cmdReady;
  logic     hsync;
  logic     vsync;
  logic     blankN;
  rgb_t     pixel;

  // scoreboard
  colorCode_t canvasModel [65536];
  rgb_t       paletteModel [8];

  logic [31:0] lfsrState;

  // screen position rebuilt from the sync edges
  screenCoord_t px;
  screenCoord_t py;
  logic         hLock;
  logic         vLock;
  logic         prevH;
  logic         prevV;
  logic         checking;
  int           activeCount;
  int           hLowCount;
  int           vLowCount;

  clockGen clockGen_i (.clk, .rst);

  vgaPaint vgaPaint_i (
    .clk, .rst, .cmdByte, .cmdValid, .cmdReady,
    .hsync, .vsync, .blankN, .pixel
  );

  task automatic stopWithFailure();
    $display("Verification failed");
    $fatal(1);
  endtask

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] bits;
    logic        lsb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lsb       = lfsrState[0];
      lfsrState = {1'b0, lfsrState[31:1]} ^ (lsb ? 32'h80200003 : 32'h0);
      bits      = {bits[30:0], lsb};
    end
    return bits;
  endfunction

  // full-scale primaries from the code bits at power-up
  function automatic rgb_t primaryColor(input colorCode_t code);
    rgb_t col;
    col.r = code[2] ? 4'hF : 4'h0;
    col.g = code[1] ? 4'hF : 4'h0;
    col.b = code[0] ? 4'hF : 4'h0;
    return col;
  endfunction

  task automatic checkRgb(input string what, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
      $display("error: %s expected %h got %h at x=%0d y=%0d", what, exp, got, px, py);
      stopWithFailure();
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s expected %h got %h at x=%0d y=%0d", what, exp, got, px, py);
      stopWithFailure();
    end
  endtask

  task automatic checkCount(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("error: %s expected %h got %h", what, exp, got);
      stopWithFailure();
    end
  endtask

  // expected port state at the tracked position
  task automatic checkPixelState();
    logic        expH;
    logic        expV;
    logic        expA;
    rgb_t        expPix;
    logic [15:0] addr;
    // sync runs from the end of the front porch to the start of the back porch
    expH   = (px < hActive + hFrontPorch) || (px >= hTotal - hBackPorch);
    expV   = (py < vActive + vFrontPorch) || (py >= vTotal - vBackPorch);
    expA   = (px < hActive) && (py < vActive);
    // canvas tiles on the low byte of each coordinate
    addr   = {py[7:0], px[7:0]};
    expPix = '0;
    if (expA) begin
      expPix = paletteModel[canvasModel[addr]];
    end
    checkBit("hsync", hsync, expH);
    checkBit("vsync", vsync, expV);
    checkBit("blankN", blankN, expA);
    checkRgb("pixel", pixel, expPix);
    if (blankN) activeCount++;
    if (!hsync) hLowCount++;
    if (!vsync) vLowCount++;
  endtask

  // outputs sampled half a cycle after they change
  always @(negedge clk) begin
    if (rst) begin
      hLock = 1'b0;
      vLock = 1'b0;
      prevH = 1'b1;
      prevV = 1'b1;
    end else begin
      // hsync rises where the back porch starts
      if (!prevH && hsync) begin
        px    = hTotal - hBackPorch;
        hLock = 1'b1;
      end else if (px == hLast) begin
        px = '0;
        py = (py == vLast) ? '0 : py + 10'd1;
      end else begin
        px = px + 10'd1;
      end
      // vsync rises on the first back porch line
      if (!prevV && vsync) begin
        py    = vTotal - vBackPorch;
        vLock = 1'b1;
      end
      prevH = hsync;
      prevV = vsync;
      if (checking) checkPixelState();
    end
  end

  task automatic sendByte(input cmdByte_t b);
    int gap;
    int waited;
    gap    = int'(randBits(2));
    waited = 0;
    // idle gap of 0 to 3 cycles
    if (gap > 0) begin
      @(negedge clk);
      cmdValid = 1'b0;
      repeat (gap - 1) @(negedge clk);
    end
    @(negedge clk);
    cmdByte  = b;
    cmdValid = 1'b1;
    while (!cmdReady) begin
      if (waited == readyTimeout) begin
        $display("cmdReady stayed low while a byte was offered");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
    end
    // transfer on this edge
    @(posedge clk);
  endtask

  task automatic sendCommand(input cmdByte_t b0, input cmdByte_t b1, input cmdByte_t b2);
    sendByte(b0);
    sendByte(b1);
    sendByte(b2);
    // issue cycle
    @(negedge clk);
    checkBit("cmdReady", cmdReady, 1'b0);
  endtask

  task automatic paintPixel(input canvasCoord_t x, input canvasCoord_t y, input colorCode_t code);
    sendCommand({opPaint, 3'b000, code}, x, y);
    canvasModel[{y, x}] = code;
  endtask

  task automatic setPalette(input colorCode_t idx, input rgb_t col);
    sendCommand({opPalette, 3'b000, idx}, {col.r, col.g}, {4'h0, col.b});
    paletteModel[idx] = col;
  endtask

  task automatic idleBus();
    @(negedge clk);
    cmdValid = 1'b0;
  endtask

  // start of vertical blanking far from any active read
  task automatic waitBlankStart();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!(hLock && vLock && (px == '0) && (py == vActive))) begin
      if (waited == lockTimeout) begin
        $display("no frame position found from hsync and vsync");
        stopWithFailure();
      end
      waited++;
      @(posedge clk);
    end
  endtask

  // compare every port cycle for one whole frame
  task automatic checkFrame(input string name);
    waitBlankStart();
    activeCount = 0;
    hLowCount   = 0;
    vLowCount   = 0;
    checking    = 1'b1;
    repeat (frameCycles) @(posedge clk);
    checking = 1'b0;
    checkCount("blankN high cycles", activeCount, int'(hActive) * int'(vActive));
    checkCount("hsync low cycles", hLowCount, int'(hSyncWidth) * int'(vTotal));
    checkCount("vsync low cycles", vLowCount, int'(vSyncWidth) * int'(hTotal));
    $display("%s: frame matched", name);
  endtask

  task automatic testResetAndSync();
    int waited;
    waited = 0;
    @(negedge clk);
    while (rst) begin
      if (waited == 32) begin
        $display("reset was never released");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
    end
    checkBit("hsync", hsync, 1'b1);
    checkBit("vsync", vsync, 1'b1);
    checkBit("blankN", blankN, 1'b0);
    checkRgb("pixel", pixel, '0);
    checkBit("cmdReady", cmdReady, 1'b1);
    // sync timing and blanking on the untouched canvas
    checkFrame("reset and sync timing");
  endtask

  task automatic testDefaultPaint();
    logic [31:0] r;
    r = randBits(16);
    paintPixel(r[7:0], r[15:8], 3'd5);
    idleBus();
    checkFrame("default palette paint");
  endtask

  task automatic testPaletteRewrite();
    logic [31:0] r;
    r = randBits(12);
    setPalette(3'd5, r[11:0]);
    idleBus();
    checkFrame("palette rewrite");
  endtask

  task automatic testStreamGaps();
    logic [31:0] r;
    // back to the power-up entry
    setPalette(3'd5, primaryColor(3'd5));
    for (int i = 0; i < 20; i++) begin
      r = randBits(19);
      paintPixel(r[7:0], r[15:8], r[18:16]);
    end
    idleBus();
    checkFrame("stream under gaps");
  endtask

  task automatic testTiling();
    logic [31:0] r;
    colorCode_t  code;
    // x and y below 128 so every tile copy is visible
    r    = randBits(17);
    code = r[16:14];
    if (code == 3'd0) code = 3'd7;
    paintPixel({1'b0, r[6:0]}, {1'b0, r[13:7]}, code);
    idleBus();
    checkFrame("tiling");
  endtask

  initial begin
    checking  = 1'b0;
    cmdByte   = '0;
    cmdValid  = 1'b0;
    lfsrState = 32'h640a;
    px        = '0;
    py        = '0;
    for (int a = 0; a < 65536; a++) canvasModel[a] = '0;
    for (int c = 0; c < 8; c++) paletteModel[c] = primaryColor(colorCode_t'(c));
    testResetAndSync();
    testDefaultPaint();
    testPaletteRewrite();
    testStreamGaps();
    testTiling();
    $display("Verification passed");
    $finish;
  end

  // overall limit of about 35 frames
  initial begin
    #150000000;
    $display("simulation ran past its time limit");
    stopWithFailure();
  end

endmodule

//--- vgaPaint.f
source/vgaTimingPkg.sv
source/paintPkg.sv
source/vgaController.sv
source/paintCommandDecoder.sv
source/pixelStore.sv
source/paletteRegs.sv
source/pixelOutput.sv
source/vgaPaint.sv
sim/clockGen.sv
sim/vgaPaint_asserts.sv
sim/vgaPaintTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module vgaPaintTb \
  -f vgaPaint.f \
  -o vgaPaintSim

simOut=$(./obj_dir/vgaPaintSim 2>&1) || true
echo "$simOut"

if grep -qx "Verification passed" <<< "$simOut"; then
  exit 0
fi
exit 1
